/* Makefile */
SRCS := soc_config.svh soc_pkg.sv uart_rx.sv prog_loader.sv inst_sram.sv \
        data_sram.sv soc_top.sv tb_soc_top.sv

.PHONY: all run clean

all: obj_dir/Vtb_soc_top

obj_dir/Vtb_soc_top: flist.f $(SRCS)
	verilator --binary -j 0 --top-module tb_soc_top -f flist.f

run: obj_dir/Vtb_soc_top
	./obj_dir/Vtb_soc_top

clean:
	rm -rf obj_dir

/* data_sram.sv */
`timescale 1ns/10ps
`include "soc_config.svh"

module data_sram (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  soc_pkg::bus_req_t req_i,
    output soc_pkg::bus_rsp_t rsp_o
);

    localparam int IDX_W = $bits(soc_pkg::data_idx_t);

    soc_pkg::word_t     mem [`SOC_DATA_WORDS];
    soc_pkg::data_idx_t idx;
    soc_pkg::word_t     rdata_q;
    logic               wr_en;
    logic               rvalid_q;

    // Upper address bits ignored, so accesses wrap
    assign idx   = req_i.addr[IDX_W+1:2];
    assign wr_en = req_i.req & req_i.we;

    //////////////////////////////////////////////////
    // Byte-lane array
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            for (int lane = 0; lane < `SOC_BE_W; lane++) begin
                if (req_i.be[lane]) begin
                    mem[idx][lane*8 +: 8] <= req_i.wdata[lane*8 +: 8];
                end
            end
        end
        if (req_i.req) begin
            // Stores answer with zero
            rdata_q <= req_i.we ? '0 : mem[idx];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i.req;
        end
    end

    // Always ready
    assign rsp_o.gnt    = req_i.req;
    assign rsp_o.rvalid = rvalid_q;
    assign rsp_o.rdata  = rdata_q;

endmodule

/* flist.f */
+incdir+.
soc_pkg.sv
uart_rx.sv
prog_loader.sv
inst_sram.sv
data_sram.sv
soc_top.sv
tb_soc_top.sv

/* inst_sram.sv */
`timescale 1ns/10ps
`include "soc_config.svh"

module inst_sram (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  logic                prog_en_i,
    input  soc_pkg::prog_wr_t   wr_i,
    input  soc_pkg::fetch_req_t fetch_req_i,
    output soc_pkg::bus_rsp_t   fetch_rsp_o
);

    localparam int IDX_W = $bits(soc_pkg::inst_idx_t);

    soc_pkg::word_t     mem [`SOC_INST_WORDS];
    soc_pkg::inst_idx_t fetch_idx;
    soc_pkg::word_t     rdata_q;
    logic               gnt;
    logic               rvalid_q;

    assign fetch_idx = fetch_req_i.addr[IDX_W+1:2];

    // No fetches while the programmer owns the array
    assign gnt = fetch_req_i.req & ~prog_en_i;

    //////////////////////////////////////////////////
    // Array, programmer write and fetch read
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (wr_i.en) begin
            mem[wr_i.idx] <= wr_i.data;
        end
        // Read before write on a collision
        if (gnt) begin
            rdata_q <= mem[fetch_idx];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= gnt;
        end
    end

    assign fetch_rsp_o.gnt    = gnt;
    assign fetch_rsp_o.rvalid = rvalid_q;
    assign fetch_rsp_o.rdata  = rdata_q;

endmodule

/* prog_loader.sv */
`timescale 1ns/10ps
`include "soc_config.svh"

module prog_loader (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              prog_en_i,
    input  soc_pkg::byte_t    byte_i,
    input  logic              byte_valid_i,
    output soc_pkg::prog_wr_t wr_o
);

    localparam int WORD_W = $bits(soc_pkg::word_t);
    localparam soc_pkg::inst_idx_t START_IDX = soc_pkg::inst_idx_t'(`SOC_INST_BASE >> 2);

    logic               prog_en_q;
    logic               prog_rise;
    logic               take_byte;
    logic               word_done;
    logic [1:0]         byte_cnt_q;
    soc_pkg::inst_idx_t idx_q;
    soc_pkg::word_t     shift_q;
    soc_pkg::word_t     assembled;
    logic               wr_en_q;
    soc_pkg::inst_idx_t wr_idx_q;
    soc_pkg::word_t     wr_data_q;

    assign prog_rise = prog_en_i & ~prog_en_q;
    assign take_byte = prog_en_i & byte_valid_i & ~prog_rise;
    assign word_done = take_byte & (byte_cnt_q == 2'd3);

    // Little-endian, newest byte lands on top
    assign assembled = {byte_i, shift_q[WORD_W-1:8]};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            prog_en_q  <= 1'b0;
            byte_cnt_q <= '0;
            idx_q      <= START_IDX;
            wr_en_q    <= 1'b0;
        end else begin
            prog_en_q <= prog_en_i;
            wr_en_q   <= word_done;
            // Partial word is lost once enable drops
            if (prog_rise || !prog_en_i) begin
                byte_cnt_q <= '0;
            end else if (take_byte) begin
                byte_cnt_q <= byte_cnt_q + 1'b1;
            end
            if (prog_rise) begin
                idx_q <= START_IDX;
            end else if (word_done) begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_byte) begin
            shift_q <= assembled;
        end
        if (word_done) begin
            wr_idx_q  <= idx_q;
            wr_data_q <= assembled;
        end
    end

    assign wr_o.en   = wr_en_q;
    assign wr_o.idx  = wr_idx_q;
    assign wr_o.data = wr_data_q;

endmodule

/* soc_config.svh */
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

//////////////////////////////////////////////////
// Bus geometry
//////////////////////////////////////////////////

`define SOC_WORD_W 32
`define SOC_BE_W   4

//////////////////////////////////////////////////
// Memory map
//////////////////////////////////////////////////

// Depths in words, 8 KB each
`define SOC_INST_WORDS 2048
`define SOC_DATA_WORDS 2048

// First byte address written by the programmer
`define SOC_INST_BASE 32'h0000_0000

// Programmer line bit period in clocks
`define SOC_UART_CLKS_PER_BIT 16

`endif

/* soc_pkg.sv */
`include "soc_config.svh"

package soc_pkg;

    typedef logic [7:0]                          byte_t;
    typedef logic [`SOC_WORD_W-1:0]              word_t;
    typedef logic [31:0]                         addr_t;
    typedef logic [`SOC_BE_W-1:0]                be_t;
    typedef logic [$clog2(`SOC_INST_WORDS)-1:0]  inst_idx_t;
    typedef logic [$clog2(`SOC_DATA_WORDS)-1:0]  data_idx_t;

    // Instruction fetch request
    typedef struct packed {
        logic  req;
        addr_t addr;
    } fetch_req_t;

    // Load/store request
    typedef struct packed {
        logic  req;
        logic  we;
        be_t   be;
        addr_t addr;
        word_t wdata;
    } bus_req_t;

    // Shared by both memory ports
    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } bus_rsp_t;

    // Programmer write, one-cycle strobe
    typedef struct packed {
        logic      en;
        inst_idx_t idx;
        word_t     data;
    } prog_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_rx_state_e;

endpackage

/* soc_top.sv */
`timescale 1ns/10ps

module soc_top (
    input  logic                clk_i,
    input  logic                arst_n_i,

    // Programmer line
    input  logic                prog_en_i,
    input  logic                prog_rx_i,

    // Fetch port
    input  soc_pkg::fetch_req_t fetch_req_i,
    output soc_pkg::bus_rsp_t   fetch_rsp_o,

    // Load/store port
    input  soc_pkg::bus_req_t   data_req_i,
    output soc_pkg::bus_rsp_t   data_rsp_o
);

    soc_pkg::byte_t    rx_byte;
    logic              rx_byte_valid;
    soc_pkg::prog_wr_t prog_wr;

    //////////////////////////////////////////////////
    // Programmer
    //////////////////////////////////////////////////

    uart_rx u_uart_rx (
        .clk_i        ( clk_i         ),
        .arst_n_i     ( arst_n_i      ),
        .rx_i         ( prog_rx_i     ),
        .byte_o       ( rx_byte       ),
        .byte_valid_o ( rx_byte_valid )
    );

    prog_loader u_prog_loader (
        .clk_i        ( clk_i         ),
        .arst_n_i     ( arst_n_i      ),
        .prog_en_i    ( prog_en_i     ),
        .byte_i       ( rx_byte       ),
        .byte_valid_i ( rx_byte_valid ),
        .wr_o         ( prog_wr       )
    );

    //////////////////////////////////////////////////
    // Memories
    //////////////////////////////////////////////////

    inst_sram u_inst_sram (
        .clk_i        ( clk_i         ),
        .arst_n_i     ( arst_n_i      ),
        .prog_en_i    ( prog_en_i     ),
        .wr_i         ( prog_wr       ),
        .fetch_req_i  ( fetch_req_i   ),
        .fetch_rsp_o  ( fetch_rsp_o   )
    );

    data_sram u_data_sram (
        .clk_i        ( clk_i         ),
        .arst_n_i     ( arst_n_i      ),
        .req_i        ( data_req_i    ),
        .rsp_o        ( data_rsp_o    )
    );

endmodule

/* tb_soc_top.sv */
`timescale 1ns/10ps
`include "soc_config.svh"

module tb_soc_top;

    localparam int CLKS_PER_BIT = `SOC_UART_CLKS_PER_BIT;
    localparam int START_IDX    = `SOC_INST_BASE / 4;
    // Ten bits per byte over every byte the tests send
    localparam int UART_BITS    = (256 + 6 + 8) * 10;
    localparam int BUS_CYCLES   = 1500;
    localparam int WATCHDOG_NS  = 2 * (UART_BITS * CLKS_PER_BIT * 4 + BUS_CYCLES * 4);

    logic                clk_i;
    logic                arst_n_i;
    logic                prog_en_i;
    logic                prog_rx_i;
    soc_pkg::fetch_req_t fetch_req;
    soc_pkg::bus_rsp_t   fetch_rsp;
    soc_pkg::bus_req_t   data_req;
    soc_pkg::bus_rsp_t   data_rsp;

    logic [31:0]         lfsr_q;
    string               test_name;
    soc_pkg::byte_t      bytes_q[$];
    soc_pkg::word_t      inst_model [`SOC_INST_WORDS];
    // Small window whose upper address bit toggles to exercise wrap
    soc_pkg::word_t      data_model [16];
    // Load/store port carried a request in the previous cycle
    logic                data_prev_req;

    soc_top dut (
        .clk_i       ( clk_i     ),
        .arst_n_i    ( arst_n_i  ),
        .prog_en_i   ( prog_en_i ),
        .prog_rx_i   ( prog_rx_i ),
        .fetch_req_i ( fetch_req ),
        .fetch_rsp_o ( fetch_rsp ),
        .data_req_i  ( data_req  ),
        .data_rsp_o  ( data_rsp  )
    );

    always #2 clk_i = ~clk_i;

    //////////////////////////////////////////////////
    // Random numbers and checks
    //////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return r;
    endfunction

    task automatic fail_run();
        $display("Test FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_word(input string what, input soc_pkg::word_t exp,
                              input soc_pkg::word_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
            fail_run();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act);
            fail_run();
        end
    endtask

    task automatic step();
        @(negedge clk_i);
    endtask

    // Midway through the low phase, before the next rising edge
    task automatic settle();
        #1;
    endtask

    //////////////////////////////////////////////////
    // Programmer line and instruction side
    //////////////////////////////////////////////////

    task automatic send_byte(input soc_pkg::byte_t b);
        prog_rx_i = 1'b0;
        repeat (CLKS_PER_BIT) step();
        for (int i = 0; i < 8; i++) begin
            prog_rx_i = b[i];
            repeat (CLKS_PER_BIT) step();
        end
        prog_rx_i = 1'b1;
        repeat (CLKS_PER_BIT) step();
    endtask

    // Whole little-endian words only, from the start index
    function automatic void load_model();
        for (int w = 0; w < bytes_q.size() / 4; w++) begin
            inst_model[START_IDX + w] = {bytes_q[4*w+3], bytes_q[4*w+2],
                                         bytes_q[4*w+1], bytes_q[4*w]};
        end
    endfunction

    task automatic program_bytes(input int count);
        bytes_q.delete();
        prog_en_i = 1'b1;
        repeat (2) step();
        for (int i = 0; i < count; i++) begin
            bytes_q.push_back(soc_pkg::byte_t'(rand_bits(8)));
            send_byte(bytes_q[i]);
        end
        repeat (4) step();
        prog_en_i = 1'b0;
        repeat (2) step();
        load_model();
    endtask

    task automatic fetch_one(input int idx);
        fetch_req.req  = 1'b1;
        fetch_req.addr = soc_pkg::addr_t'(idx * 4);
        settle();
        check_bit("fetch gnt", 1'b1, fetch_rsp.gnt);
        check_bit("fetch rvalid before edge", 1'b0, fetch_rsp.rvalid);
        step();
        check_bit("fetch rvalid", 1'b1, fetch_rsp.rvalid);
        check_word("fetch rdata", inst_model[idx], fetch_rsp.rdata);
        fetch_req.req = 1'b0;
        step();
        check_bit("fetch rvalid after idle", 1'b0, fetch_rsp.rvalid);
    endtask

    //////////////////////////////////////////////////
    // Data side
    //////////////////////////////////////////////////

    task automatic data_access(input logic we, input soc_pkg::be_t be, input logic [3:0] win,
                               input logic wrap, input soc_pkg::word_t wdata);
        soc_pkg::word_t exp;
        exp            = we ? '0 : data_model[win];
        data_req.req   = 1'b1;
        data_req.we    = we;
        data_req.be    = be;
        data_req.addr  = {18'd0, wrap, 7'd0, win, 2'b00};
        data_req.wdata = wdata;
        settle();
        check_bit("data gnt", 1'b1, data_rsp.gnt);
        check_bit("data rvalid before edge", data_prev_req, data_rsp.rvalid);
        step();
        check_bit("data rvalid", 1'b1, data_rsp.rvalid);
        check_word("data rdata", exp, data_rsp.rdata);
        data_prev_req = 1'b1;
        if (we) begin
            for (int l = 0; l < `SOC_BE_W; l++) begin
                if (be[l]) begin
                    data_model[win][l*8 +: 8] = wdata[l*8 +: 8];
                end
            end
        end
    endtask

    task automatic data_idle();
        data_req.req = 1'b0;
        step();
        check_bit("data gnt idle", 1'b0, data_rsp.gnt);
        check_bit("data rvalid idle", 1'b0, data_rsp.rvalid);
        data_prev_req = 1'b0;
    endtask

    task automatic data_traffic();
        logic [31:0]    r;
        logic           we;
        logic           wrap;
        soc_pkg::be_t   be;
        logic [3:0]     win;
        soc_pkg::word_t wd;
        // Known contents first
        for (int i = 0; i < 16; i++) begin
            data_access(1'b1, 4'hf, 4'(i), 1'b0, rand_bits(32));
        end
        for (int n = 0; n < 300; n++) begin
            r = rand_bits(2);
            if (r[1:0] == 2'd0) begin
                data_idle();
            end
            r    = rand_bits(1);
            we   = r[0];
            r    = rand_bits(4);
            be   = r[3:0];
            r    = rand_bits(4);
            win  = r[3:0];
            r    = rand_bits(1);
            wrap = r[0];
            wd   = rand_bits(32);
            data_access(we, be, win, wrap, wd);
        end
        data_idle();
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in %0d ns", WATCHDOG_NS);
        fail_run();
    end

    initial begin
        clk_i         = 1'b0;
        arst_n_i      = 1'b0;
        prog_en_i     = 1'b0;
        prog_rx_i     = 1'b1;
        fetch_req     = '0;
        data_req      = '0;
        data_prev_req = 1'b0;
        lfsr_q        = 32'h1d575f6e;
        repeat (3) step();
        arst_n_i = 1'b1;

        test_name = "reset_idle";
        repeat (8) begin
            step();
            check_bit("fetch gnt", 1'b0, fetch_rsp.gnt);
            check_bit("fetch rvalid", 1'b0, fetch_rsp.rvalid);
            check_bit("data gnt", 1'b0, data_rsp.gnt);
            check_bit("data rvalid", 1'b0, data_rsp.rvalid);
        end

        test_name = "load_and_fetch";
        program_bytes(256);
        for (int i = 0; i < 64; i++) begin
            fetch_one(i);
        end

        test_name = "fetch_blocked";
        fetch_req.req  = 1'b1;
        fetch_req.addr = soc_pkg::addr_t'(5 * 4);
        prog_en_i      = 1'b1;
        repeat (8) begin
            step();
            check_bit("fetch gnt", 1'b0, fetch_rsp.gnt);
            check_bit("fetch rvalid", 1'b0, fetch_rsp.rvalid);
        end
        prog_en_i = 1'b0;
        settle();
        check_bit("fetch gnt", 1'b1, fetch_rsp.gnt);
        check_bit("fetch rvalid before edge", 1'b0, fetch_rsp.rvalid);
        step();
        check_bit("fetch rvalid", 1'b1, fetch_rsp.rvalid);
        check_word("fetch rdata", inst_model[5], fetch_rsp.rdata);
        fetch_req.req = 1'b0;
        step();
        check_bit("fetch rvalid after idle", 1'b0, fetch_rsp.rvalid);

        test_name = "restart_partial";
        program_bytes(6);
        program_bytes(8);
        for (int i = 0; i < 4; i++) begin
            fetch_one(i);
        end

        test_name = "data_random";
        data_traffic();

        test_name = "fetch_burst";
        for (int i = 0; i < 64; i++) begin
            fetch_req.req  = 1'b1;
            fetch_req.addr = soc_pkg::addr_t'(i * 4);
            settle();
            check_bit("fetch gnt", 1'b1, fetch_rsp.gnt);
            check_bit("fetch rvalid before edge", i > 0, fetch_rsp.rvalid);
            step();
            check_bit("fetch rvalid", 1'b1, fetch_rsp.rvalid);
            check_word("fetch rdata", inst_model[i], fetch_rsp.rdata);
        end
        fetch_req.req = 1'b0;
        step();
        check_bit("fetch rvalid after burst", 1'b0, fetch_rsp.rvalid);

        $display("Test OK");
        $finish;
    end

endmodule

/* uart_rx.sv */
`timescale 1ns/10ps
`include "soc_config.svh"

module uart_rx (
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  logic           rx_i,
    output soc_pkg::byte_t byte_o,
    output logic           byte_valid_o
);

    localparam int CLKS_PER_BIT = `SOC_UART_CLKS_PER_BIT;
    localparam int CNT_W        = $clog2(CLKS_PER_BIT);

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(CLKS_PER_BIT / 2 - 1);
    // Clocks already lost in the synchronizer
    localparam logic [CNT_W-1:0] CNT_SYNC = CNT_W'(2);

    logic                    rx_meta_q;
    logic                    rx_sync_q;
    soc_pkg::uart_rx_state_e state_q;
    logic [CNT_W-1:0]        cnt_q;
    logic [2:0]              bit_q;
    soc_pkg::byte_t          shift_q;
    logic                    valid_q;

    //////////////////////////////////////////////////
    // Line synchronizer
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    //////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= soc_pkg::IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state_q)
                soc_pkg::IDLE: begin
                    if (!rx_sync_q) begin
                        state_q <= soc_pkg::START;
                        cnt_q   <= CNT_SYNC;
                    end
                end
                soc_pkg::START: begin
                    if (cnt_q == CNT_MID) begin
                        cnt_q   <= '0;
                        bit_q   <= '0;
                        // Line back high means a glitch
                        state_q <= rx_sync_q ? soc_pkg::IDLE : soc_pkg::DATA;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                soc_pkg::DATA: begin
                    if (cnt_q == CNT_LAST) begin
                        cnt_q <= '0;
                        bit_q <= bit_q + 1'b1;
                        if (bit_q == 3'd7) begin
                            state_q <= soc_pkg::STOP;
                        end
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                soc_pkg::STOP: begin
                    if (cnt_q == CNT_LAST) begin
                        cnt_q   <= '0;
                        // Framing error drops the byte
                        valid_q <= rx_sync_q;
                        state_q <= soc_pkg::IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= soc_pkg::IDLE;
                end
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk_i) begin
        if (state_q == soc_pkg::DATA && cnt_q == CNT_LAST) begin
            shift_q <= {rx_sync_q, shift_q[7:1]};
        end
    end

    assign byte_o       = shift_q;
    assign byte_valid_o = valid_q;

endmodule
